// ==== filelist.f ====
+incdir+src
src/debugHostPkg.sv
src/debugCpuPkg.sv
src/debugCtrlIf.sv
src/debugHostRegs.sv
src/debugReqFsm.sv
src/debugAddrCounter.sv
src/debugPort.sv
verification/debugPort_props.sv
verification/debugPortTb.sv

// ==== src/debugAddrCounter.sv ====
`timescale 1ns/10ps
`include "debugPort_params.svh"

module debugAddrCounter (
	input  logic                      CLK,
	input  logic                      rst,
	input  logic                      addrLdX,
	input  logic                      addrIncX,
	input  logic [`DEBUG_DATA_W-1:0]  loadAddr,
	output logic [`DEBUG_DATA_W-1:0]  memAddr
);

	localparam logic [`DEBUG_DATA_W-1:0] addrStep = `DEBUG_ADDR_STEP;

	// Load wins over increment
	always_ff @(posedge CLK) begin
		if (rst) begin
			memAddr <= '0;
		end else if (addrLdX) begin
			memAddr <= loadAddr;
		end else if (addrIncX) begin
			memAddr <= memAddr + addrStep;
		end
	end

endmodule

// ==== src/debugCpuPkg.sv ====
package debugCpuPkg;

	// Register file select
	typedef enum logic [3:0] {
		r0, r1, r2, r3,
		r4, r5, r6, r7,
		r8, r9, r10, r11,
		r12, r13, r14, r15
	} regSelE;

	// Next-PC choice
	typedef enum logic [1:0] {
		pcNextNext   = 2'd0,
		pcNextBranch = 2'd1,
		pcNextJump   = 2'd2,
		pcNextRet    = 2'd3
	} pcNextE;

	// Condition code choice
	typedef enum logic [1:0] {
		ccRun   = 2'd0,
		ccKeep  = 2'd1,
		ccLoad  = 2'd2,
		ccClear = 2'd3
	} ccRegE;

	// Request FSM states
	typedef enum logic [1:0] {
		stRun     = 2'd0,
		stIdle    = 2'd1,
		stRequest = 2'd2,
		stWaitAck = 2'd3
	} fsmStateE;

endpackage

// ==== src/debugCtrlIf.sv ====
`timescale 1ns/10ps

interface debugCtrlIf;
	import debugHostPkg::*;

	// Strobes from the host registers
	logic    stopWrite;
	logic    stopValue;
	logic    opWrite;
	debugOpE opcode;

	// Status back from the FSM
	logic    busy;
	logic    stopped;

	modport regs (
		output stopWrite,
		output stopValue,
		output opWrite,
		output opcode,
		input  busy,
		input  stopped
	);

	modport fsm (
		input  stopWrite,
		input  stopValue,
		input  opWrite,
		input  opcode,
		output busy,
		output stopped
	);

endinterface

// ==== src/debugHostPkg.sv ====
package debugHostPkg;

	// Host register map
	typedef enum logic [2:0] {
		regStop    = 3'd0,
		regMah     = 3'd1,
		regMal     = 3'd2,
		regMdh     = 3'd3,
		regMdl     = 3'd4,
		regOpx     = 3'd5,
		regSourcex = 3'd6,
		regDatax   = 3'd7
	} hostRegE;

	// Debug operations handed to the core
	typedef enum logic [2:0] {
		opNone  = 3'd0,
		opRdReg = 3'd1,
		opWrReg = 3'd2,
		opRdMem = 3'd3,
		opWrMem = 3'd4
	} debugOpE;

	// Capture source for the memory data register
	typedef enum logic [1:0] {
		srcDin    = 2'd0,
		srcRegA   = 2'd1,
		srcCc     = 2'd2,
		srcPcNext = 2'd3
	} dataSrcE;

endpackage

// ==== src/debugHostRegs.sv ====
`timescale 1ns/10ps
`include "debugPort_params.svh"

module debugHostRegs (
	input  logic                       CLK,
	input  logic                       rst,
	input  logic [2:0]                 hostAddr,
	input  logic [`DEBUG_HOST_W-1:0]   hostDin,
	output logic [`DEBUG_HOST_W-1:0]   hostDout,
	input  logic                       hostRd,
	input  logic                       hostWr,
	debugCtrlIf.regs                   ctrl,
	input  logic [`DEBUG_DATA_W-1:0]   dinDin,
	input  logic [`DEBUG_DATA_W-1:0]   regAData,
	input  logic [`DEBUG_DATA_W-1:0]   ccData,
	input  logic [`DEBUG_DATA_W-1:0]   pcANext,
	input  logic                       doutLdX,
	output debugCpuPkg::regSelE        regX,
	output debugCpuPkg::pcNextE        pcNextX,
	output debugCpuPkg::ccRegE         ccRegX,
	output logic [`DEBUG_DATA_W-1:0]   memDataOut,
	output logic [`DEBUG_DATA_W-1:0]   loadAddr
);
	import debugHostPkg::*;
	import debugCpuPkg::*;

	logic                     hostWrQ;
	logic                     hostWrQ2;
	logic                     wrStrobe;
	hostRegE                  wrAddr;
	logic [`DEBUG_HOST_W-1:0] wrData;
	logic [`DEBUG_HOST_W-1:0] mah;
	logic [`DEBUG_HOST_W-1:0] mal;
	logic [`DEBUG_HOST_W-1:0] sourceX;
	dataSrcE                  dataX;
	debugOpE                  opReg;
	debugOpE                  opSel;
	logic [`DEBUG_DATA_W-1:0] memData;
	logic [`DEBUG_DATA_W-1:0] capData;
	logic [`DEBUG_HOST_W-1:0] readData;

	// Sample the write strobe, then register one pulse per rising edge
	always_ff @(posedge CLK) begin
		if (rst) begin
			hostWrQ  <= 1'b0;
			hostWrQ2 <= 1'b0;
			wrStrobe <= 1'b0;
		end else begin
			hostWrQ  <= hostWr;
			hostWrQ2 <= hostWrQ;
			wrStrobe <= hostWrQ & ~hostWrQ2;
		end
	end

	always_ff @(posedge CLK) begin
		wrAddr <= hostRegE'(hostAddr);
		wrData <= hostDin;
	end

	// Unknown opcodes are treated as no operation
	always_comb begin
		if (wrData[2:0] > opWrMem) begin
			opSel = opNone;
		end else begin
			opSel = debugOpE'(wrData[2:0]);
		end
	end

	assign ctrl.stopWrite = wrStrobe && (wrAddr == regStop);
	assign ctrl.stopValue = wrData[0];
	assign ctrl.opWrite   = wrStrobe && (wrAddr == regOpx);
	assign ctrl.opcode    = opSel;

	always_ff @(posedge CLK) begin
		if (wrStrobe && wrAddr == regMah) begin
			mah <= wrData;
		end
		if (wrStrobe && wrAddr == regMal) begin
			mal <= wrData;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			sourceX <= '0;
			dataX   <= srcDin;
			opReg   <= opNone;
		end else if (wrStrobe) begin
			case (wrAddr)
				regSourcex: sourceX <= wrData;
				regDatax:   dataX   <= dataSrcE'(wrData[1:0]);
				regOpx:     opReg   <= opSel;
				default:    ;
			endcase
		end
	end

	always_comb begin
		case (dataX)
			srcDin:    capData = dinDin;
			srcRegA:   capData = regAData;
			srcCc:     capData = ccData;
			default:   capData = pcANext;
		endcase
	end

	// Core load has priority over host byte writes
	always_ff @(posedge CLK) begin
		if (rst) begin
			memData <= '0;
		end else if (doutLdX) begin
			memData <= capData;
		end else if (wrStrobe && wrAddr == regMdh) begin
			memData[`DEBUG_DATA_W-1:`DEBUG_HOST_W] <= wrData;
		end else if (wrStrobe && wrAddr == regMdl) begin
			memData[`DEBUG_HOST_W-1:0] <= wrData;
		end
	end

	always_comb begin
		readData = '0;
		case (hostRegE'(hostAddr))
			regStop: begin
				readData[1] = ctrl.busy;
				readData[0] = ctrl.stopped;
			end
			regMah:     readData = mah;
			regMal:     readData = mal;
			regMdh:     readData = memData[`DEBUG_DATA_W-1:`DEBUG_HOST_W];
			regMdl:     readData = memData[`DEBUG_HOST_W-1:0];
			regOpx:     readData[2:0] = opReg;
			regSourcex: readData = sourceX;
			default:    readData[1:0] = dataX;
		endcase
	end

	// Read data holds while hostRd is low
	always_ff @(posedge CLK) begin
		if (rst) begin
			hostDout <= '0;
		end else if (hostRd) begin
			hostDout <= readData;
		end
	end

	assign regX       = regSelE'(sourceX[7:4]);
	assign pcNextX    = pcNextE'(sourceX[3:2]);
	assign ccRegX     = ccRegE'(sourceX[1:0]);
	assign memDataOut = memData;
	assign loadAddr   = {mah, mal};

endmodule

// ==== src/debugPort.sv ====
`timescale 1ns/10ps
`include "debugPort_params.svh"

module debugPort (
	input  logic                      CLK,
	input  logic                      rst,
	input  logic [2:0]                hostAddr,
	input  logic [`DEBUG_HOST_W-1:0]  hostDin,
	output logic [`DEBUG_HOST_W-1:0]  hostDout,
	input  logic                      hostRd,
	input  logic                      hostWr,
	input  logic                      addrLdX,
	input  logic                      addrIncX,
	output logic                      stopX,
	output logic                      reqX,
	input  logic                      ackX,
	output debugHostPkg::debugOpE     opX,
	output debugCpuPkg::regSelE       regX,
	output debugCpuPkg::pcNextE       pcNextX,
	output debugCpuPkg::ccRegE        ccRegX,
	output logic [`DEBUG_DATA_W-1:0]  memAddr,
	output logic [`DEBUG_DATA_W-1:0]  memDataOut,
	input  logic [`DEBUG_DATA_W-1:0]  dinDin,
	input  logic [`DEBUG_DATA_W-1:0]  regAData,
	input  logic [`DEBUG_DATA_W-1:0]  ccData,
	input  logic [`DEBUG_DATA_W-1:0]  pcANext,
	input  logic                      doutLdX
);

	logic [`DEBUG_DATA_W-1:0] loadAddr;

	debugCtrlIf ctrl ();

	debugHostRegs u_regs (
		.CLK        (CLK),
		.rst        (rst),
		.hostAddr   (hostAddr),
		.hostDin    (hostDin),
		.hostDout   (hostDout),
		.hostRd     (hostRd),
		.hostWr     (hostWr),
		.ctrl       (ctrl.regs),
		.dinDin     (dinDin),
		.regAData   (regAData),
		.ccData     (ccData),
		.pcANext    (pcANext),
		.doutLdX    (doutLdX),
		.regX       (regX),
		.pcNextX    (pcNextX),
		.ccRegX     (ccRegX),
		.memDataOut (memDataOut),
		.loadAddr   (loadAddr)
	);

	debugReqFsm u_fsm (
		.CLK   (CLK),
		.rst   (rst),
		.ctrl  (ctrl.fsm),
		.ackX  (ackX),
		.stopX (stopX),
		.reqX  (reqX),
		.opX   (opX)
	);

	debugAddrCounter u_addrCnt (
		.CLK      (CLK),
		.rst      (rst),
		.addrLdX  (addrLdX),
		.addrIncX (addrIncX),
		.loadAddr (loadAddr),
		.memAddr  (memAddr)
	);

endmodule

// ==== src/debugPort_params.svh ====
`ifndef DEBUG_PORT_PARAMS_SVH
`define DEBUG_PORT_PARAMS_SVH

// CPU word width
`define DEBUG_DATA_W 16

// Host bus is byte wide
`define DEBUG_HOST_W 8

// Addresses count bytes, the core moves by words
`define DEBUG_ADDR_STEP 2

`endif

// ==== src/debugReqFsm.sv ====
`timescale 1ns/10ps

module debugReqFsm (
	input  logic                   CLK,
	input  logic                   rst,
	debugCtrlIf.fsm                ctrl,
	input  logic                   ackX,
	output logic                   stopX,
	output logic                   reqX,
	output debugHostPkg::debugOpE  opX
);
	import debugHostPkg::*;
	import debugCpuPkg::*;

	fsmStateE state;
	debugOpE  opLatch;

	always_ff @(posedge CLK) begin
		if (rst) begin
			state   <= stRun;
			reqX    <= 1'b0;
			opLatch <= opNone;
		end else begin
			case (state)
				stRun: begin
					// Op writes are dropped while the core runs
					if (ctrl.stopWrite && ctrl.stopValue) begin
						state <= stIdle;
					end
				end
				stIdle: begin
					if (ctrl.opWrite && ctrl.opcode != opNone) begin
						state   <= stRequest;
						opLatch <= ctrl.opcode;
					end else if (ctrl.stopWrite && !ctrl.stopValue) begin
						state <= stRun;
					end
				end
				stRequest: begin
					reqX  <= 1'b1;
					state <= stWaitAck;
				end
				stWaitAck: begin
					// No limit on how long the core takes
					if (ackX) begin
						reqX  <= 1'b0;
						state <= stIdle;
					end
				end
				default: begin
					reqX  <= 1'b0;
					state <= stRun;
				end
			endcase
		end
	end

	assign stopX = (state != stRun);

	// Opcode only shown while the request is up
	assign opX = reqX ? opLatch : opNone;

	assign ctrl.busy    = (state == stRequest) || (state == stWaitAck);
	assign ctrl.stopped = stopX;

endmodule

// ==== verification/debugPortTb.sv ====
`timescale 1ns/10ps
`include "debugPort_params.svh"

module debugPortTb;
	import debugHostPkg::*;
	import debugCpuPkg::*;

	// Far above the length of the directed sequence
	localparam int maxCycles = 2000;

	logic                     CLK;
	logic                     rst;
	logic [2:0]               hostAddr;
	logic [`DEBUG_HOST_W-1:0] hostDin;
	logic [`DEBUG_HOST_W-1:0] hostDout;
	logic                     hostRd;
	logic                     hostWr;
	logic                     addrLdX;
	logic                     addrIncX;
	logic                     stopX;
	logic                     reqX;
	logic                     ackX;
	debugOpE                  opX;
	regSelE                   regX;
	pcNextE                   pcNextX;
	ccRegE                    ccRegX;
	logic [`DEBUG_DATA_W-1:0] memAddr;
	logic [`DEBUG_DATA_W-1:0] memDataOut;
	logic [`DEBUG_DATA_W-1:0] dinDin;
	logic [`DEBUG_DATA_W-1:0] regAData;
	logic [`DEBUG_DATA_W-1:0] ccData;
	logic [`DEBUG_DATA_W-1:0] pcANext;
	logic                     doutLdX;

	logic [`DEBUG_HOST_W-1:0] rdData;
	logic [`DEBUG_DATA_W-1:0] srcVals [4];
	logic [`DEBUG_DATA_W-1:0] expWord;
	integer                   seed;
	int                       delay;
	int                       errCount = 0;
	int                       propErrors;
	int                       cycles = 0;

	debugPort u_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= maxCycles) begin
			$display("Timeout: the test sequence did not finish within %0d cycles", maxCycles);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else begin
			errCount++;
			$display("FAIL %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
		end
	endtask

	// Strobe is sampled, edge detected, then written one edge later
	task automatic hostWrite(input hostRegE addr, input logic [7:0] data);
		@(posedge CLK);
		hostAddr <= addr;
		hostDin  <= data;
		hostWr   <= 1'b1;
		repeat (2) @(posedge CLK);
		hostWr <= 1'b0;
		repeat (2) @(posedge CLK);
	endtask

	task automatic hostRead(input hostRegE addr, output logic [7:0] data);
		@(posedge CLK);
		hostAddr <= addr;
		hostRd   <= 1'b1;
		@(posedge CLK);
		@(negedge CLK);
		data = hostDout;
		@(posedge CLK);
		hostRd <= 1'b0;
	endtask

	task automatic pulseCounter(input logic load, input logic inc);
		@(posedge CLK);
		addrLdX  <= load;
		addrIncX <= inc;
		@(posedge CLK);
		addrLdX  <= 1'b0;
		addrIncX <= 1'b0;
		@(negedge CLK);
	endtask

	initial begin
		seed = 32'hfb7f;
		rst      <= 1'b1;
		hostAddr <= '0;
		hostDin  <= '0;
		hostRd   <= 1'b0;
		hostWr   <= 1'b0;
		addrLdX  <= 1'b0;
		addrIncX <= 1'b0;
		ackX     <= 1'b0;
		dinDin   <= '0;
		regAData <= '0;
		ccData   <= '0;
		pcANext  <= '0;
		doutLdX  <= 1'b0;
		repeat (10) @(posedge CLK);
		rst <= 1'b0;
		@(negedge CLK);
		checkValue("reset reqX", 0, reqX);
		checkValue("reset stopX", 0, stopX);
		checkValue("reset opX", opNone, opX);
		checkValue("reset hostDout", 0, hostDout);
		checkValue("reset memAddr", 0, memAddr);
		checkValue("reset memDataOut", 0, memDataOut);
		checkValue("reset regX", 0, regX);
		checkValue("reset pcNextX", 0, pcNextX);
		checkValue("reset ccRegX", 0, ccRegX);

		hostWrite(regStop, 8'h01);
		checkValue("stop stopX", 1, stopX);
		hostRead(regStop, rdData);
		checkValue("stop readback", 8'h01, rdData);

		hostWrite(regMah, 8'h56);
		hostWrite(regMal, 8'h78);
		hostWrite(regMdh, 8'h12);
		hostWrite(regMdl, 8'h34);
		pulseCounter(1'b1, 1'b0);
		checkValue("addr load", 16'h5678, memAddr);
		checkValue("data write", 16'h1234, memDataOut);
		pulseCounter(1'b0, 1'b1);
		checkValue("addr inc", 16'h5678 + `DEBUG_ADDR_STEP, memAddr);

		// Fields split as 7:4, 3:2 and 1:0
		hostWrite(regSourcex, 8'ha7);
		checkValue("source regX", 4'ha, regX);
		checkValue("source pcNextX", 2'd1, pcNextX);
		checkValue("source ccRegX", 2'd3, ccRegX);

		for (int src = 0; src < 4; src++) begin
			hostWrite(regDatax, 8'(src));
			for (int i = 0; i < 4; i++) begin
				srcVals[i] = 16'($random(seed));
			end
			@(posedge CLK);
			dinDin   <= srcVals[srcDin];
			regAData <= srcVals[srcRegA];
			ccData   <= srcVals[srcCc];
			pcANext  <= srcVals[srcPcNext];
			doutLdX  <= 1'b1;
			@(posedge CLK);
			doutLdX <= 1'b0;
			expWord = srcVals[src];
			hostRead(regMdl, rdData);
			checkValue($sformatf("capture %0d low", src), expWord[7:0], rdData);
			hostRead(regMdh, rdData);
			checkValue($sformatf("capture %0d high", src), expWord[15:8], rdData);
		end

		// Core is stopped, so the request goes out
		delay = $unsigned($random(seed)) % 8;
		hostWrite(regOpx, opRdReg);
		@(negedge CLK);
		while (!reqX) begin
			@(negedge CLK);
		end
		checkValue("req opX", opRdReg, opX);
		// Busy and stopped both set while the request is up
		hostRead(regStop, rdData);
		checkValue("busy readback", 8'h03, rdData);
		repeat (delay) begin
			@(negedge CLK);
			checkValue("req held", 1, reqX);
		end
		@(posedge CLK);
		ackX <= 1'b1;
		@(posedge CLK);
		ackX <= 1'b0;
		@(negedge CLK);
		checkValue("ack reqX", 0, reqX);
		checkValue("ack opX", opNone, opX);

		hostWrite(regStop, 8'h00);
		checkValue("run stopX", 0, stopX);
		hostWrite(regOpx, opRdReg);
		repeat (4) begin
			@(negedge CLK);
			checkValue("run no req", 0, reqX);
		end

		propErrors = u_dut.u_props.errCount;
		$display("Summary: %0d value errors, %0d assertion errors", errCount, propErrors);
		if (errCount == 0 && propErrors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== verification/debugPort_props.sv ====
`timescale 1ns/10ps
`include "debugPort_params.svh"

module debugPortProps (
	input logic                      CLK,
	input logic                      rst,
	input logic                      reqX,
	input logic                      ackX,
	input debugHostPkg::debugOpE     opX,
	input logic                      addrLdX,
	input logic                      addrIncX,
	input logic [`DEBUG_DATA_W-1:0]  memAddr,
	input debugCpuPkg::fsmStateE     state
);
	import debugHostPkg::*;
	import debugCpuPkg::*;

	localparam logic [`DEBUG_DATA_W-1:0] addrStep = `DEBUG_ADDR_STEP;

	int errCount = 0;

	// Request held until the core answers
	reqHold: assert property (@(posedge CLK) disable iff (rst) reqX && !ackX |=> reqX)
	else begin
		errCount++;
		$error("reqX dropped before ackX was seen");
	end

	opIdle: assert property (@(posedge CLK) disable iff (rst) !reqX |-> opX == opNone)
	else begin
		errCount++;
		$error("opX is not opNone while reqX is low");
	end

	// Plain increment, no load in the same cycle
	addrStepCheck: assert property (@(posedge CLK) disable iff (rst)
		addrIncX && !addrLdX |=> memAddr == $past(memAddr) + addrStep)
	else begin
		errCount++;
		$error("memAddr did not advance by one step");
	end

	noReqInRun: assert property (@(posedge CLK) disable iff (rst) state == stRun |-> !reqX)
	else begin
		errCount++;
		$error("reqX is high while the core runs");
	end

endmodule

bind debugPort debugPortProps u_props (
	.CLK      (CLK),
	.rst      (rst),
	.reqX     (reqX),
	.ackX     (ackX),
	.opX      (opX),
	.addrLdX  (addrLdX),
	.addrIncX (addrIncX),
	.memAddr  (memAddr),
	.state    (u_fsm.state)
);
